// File: common/lc3b_cfg.svh
`ifndef LC3B_CFG_SVH
`define LC3B_CFG_SVH

// first fetch address out of reset
`define LC3B_RESET_PC 16'h0000

// architectural register count
`define LC3B_NUM_REGS 8

`endif

// File: common/lc3b_types.sv
package lc3b_types;

typedef logic [15:0] lc3b_word;
typedef logic [2:0]  lc3b_reg;
typedef logic [2:0]  lc3b_nzp;

typedef enum logic [3:0] {
    op_br  = 4'b0000,
    op_add = 4'b0001,
    op_and = 4'b0101,
    op_ldr = 4'b0110,
    op_str = 4'b0111,
    op_not = 4'b1001,
    op_lea = 4'b1110
} lc3b_opcode;

typedef enum logic [1:0] {alu_add, alu_and, alu_not, alu_pass} lc3b_alu_op;

typedef enum logic [1:0] {wb_alu, wb_mem, wb_adder} lc3b_wb_sel;

typedef struct packed {
    lc3b_alu_op alu_op;
    logic       opb_imm;     // operand b from imm5
    logic       offset6_sel; // base + offset6*2, else pc+2 + offset9*2
    logic       mem_read;
    logic       mem_write;
    logic       reg_write;
    logic       cc_write;
    logic       is_branch;
    lc3b_wb_sel wb_sel;
} lc3b_control_word;

// stage payloads
typedef struct packed {
    lc3b_word pc;
    lc3b_word instruction;
} if_id_t;

typedef struct packed {
    lc3b_word         pc;
    lc3b_word         instruction;
    lc3b_control_word ctrl;
    lc3b_reg          dest;
    lc3b_word         src1_data;
    lc3b_word         src2_data;
} id_ex_t;

typedef struct packed {
    lc3b_control_word ctrl;
    lc3b_reg          dest;
    lc3b_word         alu;
    lc3b_word         adder;
    lc3b_word         store_data;
} ex_mem_t;

typedef struct packed {
    lc3b_control_word ctrl;
    lc3b_reg          dest;
    lc3b_word         value;
} mem_wb_t;

endpackage : lc3b_types

// File: hdl/stage_buffer.sv
`timescale 1ns/1ps

module stage_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // all-zero payload is a bubble, ctrl word has no side effects
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule : stage_buffer

// File: hdl/cpu_control.sv
`timescale 1ns/1ps

module cpu_control
    import lc3b_types::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  lc3b_word         instruction,
    input  lc3b_reg          id_ex_dest,
    input  lc3b_reg          ex_mem_dest,
    input  lc3b_reg          mem_wb_dest,
    input  lc3b_control_word id_ex_ctrl,
    input  lc3b_control_word ex_mem_ctrl,
    input  lc3b_control_word mem_wb_ctrl,
    input  logic             fetch_busy,
    input  logic             mem_busy,
    input  logic             br_taken,
    output lc3b_control_word ctrl,
    output logic             stall,
    output logic             hold,
    output logic             flush,
    output logic [1:0]       pc_sel
);

    lc3b_opcode opcode;
    lc3b_reg    src1;
    lc3b_reg    src2;
    logic       use_sr1;
    logic       use_sr2;
    logic       use_cc;
    logic       reg_hazard;
    logic       cc_hazard;

    function automatic logic writes_reg(lc3b_control_word c, lc3b_reg d, lc3b_reg r);
        return c.reg_write && (d == r);
    endfunction

    assign opcode = lc3b_opcode'(instruction[15:12]);

    always_comb begin
        ctrl = '0;
        ctrl.alu_op = alu_pass;
        case (opcode)
            op_add, op_and: begin
                ctrl.alu_op    = (opcode == op_add) ? alu_add : alu_and;
                ctrl.opb_imm   = instruction[5];
                ctrl.reg_write = 1'b1;
                ctrl.cc_write  = 1'b1;
                ctrl.wb_sel    = wb_alu;
            end
            op_not: begin
                ctrl.alu_op    = alu_not;
                ctrl.reg_write = 1'b1;
                ctrl.cc_write  = 1'b1;
                ctrl.wb_sel    = wb_alu;
            end
            op_br:  ctrl.is_branch = |instruction[11:9]; // nzp=000 acts as nop
            op_lea: begin
                ctrl.reg_write = 1'b1; // lc-3b lea leaves cc alone
                ctrl.wb_sel    = wb_adder;
            end
            op_ldr: begin
                ctrl.offset6_sel = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.cc_write    = 1'b1;
                ctrl.wb_sel      = wb_mem;
            end
            op_str: begin
                ctrl.offset6_sel = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

    // source usage of the instruction in decode
    assign src1    = instruction[8:6];
    assign src2    = (opcode == op_str) ? instruction[11:9] : instruction[2:0];
    assign use_sr1 = (opcode == op_add) || (opcode == op_and) || (opcode == op_not) ||
                     (opcode == op_ldr) || (opcode == op_str);
    assign use_sr2 = (((opcode == op_add) || (opcode == op_and)) && !instruction[5]) ||
                     (opcode == op_str);
    assign use_cc  = ctrl.is_branch;

    // no forwarding, wait until every older writer has retired
    assign reg_hazard = (use_sr1 && (writes_reg(id_ex_ctrl, id_ex_dest, src1) ||
                                     writes_reg(ex_mem_ctrl, ex_mem_dest, src1) ||
                                     writes_reg(mem_wb_ctrl, mem_wb_dest, src1))) ||
                        (use_sr2 && (writes_reg(id_ex_ctrl, id_ex_dest, src2) ||
                                     writes_reg(ex_mem_ctrl, ex_mem_dest, src2) ||
                                     writes_reg(mem_wb_ctrl, mem_wb_dest, src2)));
    assign cc_hazard  = use_cc && (id_ex_ctrl.cc_write || ex_mem_ctrl.cc_write ||
                                   mem_wb_ctrl.cc_write);

    assign stall  = fetch_busy | mem_busy;  // either port waiting freezes all stages
    assign flush  = br_taken & ~stall;
    assign hold   = (reg_hazard | cc_hazard) & ~br_taken; // decode is flushed anyway
    assign pc_sel = {1'b0, flush};          // 01 selects branch target

    // a taken branch redirects once, if_id and id_ex come back as bubbles
    property p_branch_flush;
        @(posedge clk) disable iff (!rst_n)
            (br_taken && !stall) |=> (!br_taken && (instruction == 16'h0000));
    endproperty
    a_branch_flush: assert property (p_branch_flush)
        else $error("taken branch not flushed cleanly");

endmodule : cpu_control

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module fetch_unit
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       hold,
    input  logic [1:0] pc_sel,
    input  lc3b_word   br_target,
    input  logic       resp_a,
    input  lc3b_word   rdata_a,
    output logic       read_a,
    output lc3b_word   address_a,
    output lc3b_word   pc,
    output lc3b_word   instruction,
    output logic       fetch_busy
);

    lc3b_word pc_q;    // address of the instruction in flight or held
    lc3b_word held_q;
    logic     req_q;
    logic     full_q;  // held_q waiting for decode
    logic     arrived;
    logic     advance;

    assign arrived    = req_q & resp_a;
    assign advance    = ~stall & ~hold;
    assign read_a     = req_q;
    assign address_a  = pc_q;
    assign pc         = pc_q;
    assign fetch_busy = req_q & ~resp_a;

    always_comb begin
        if (full_q) begin
            instruction = held_q;
        end else if (arrived) begin
            instruction = rdata_a;
        end else begin
            instruction = 16'h0000; // br with nzp=000, never taken
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q   <= `LC3B_RESET_PC;
            req_q  <= 1'b0;
            full_q <= 1'b0;
        end else if (pc_sel == 2'b01) begin
            // any word fetched this cycle is flushed out of if_id
            pc_q   <= br_target;
            req_q  <= 1'b1;
            full_q <= 1'b0;
        end else if ((full_q | arrived) & advance) begin
            pc_q   <= pc_q + 16'd2;
            req_q  <= 1'b1;
            full_q <= 1'b0;
        end else if (arrived) begin
            req_q  <= 1'b0;  // decode busy, park the word
            full_q <= 1'b1;
        end else if (!req_q && !full_q) begin
            req_q  <= 1'b1;  // first fetch after reset
        end
    end

    always_ff @(posedge clk) begin
        if (arrived) held_q <= rdata_a;
    end

    property p_addr_stable;
        @(posedge clk) disable iff (!rst_n)
            (read_a && !resp_a) |=> $stable(address_a);
    endproperty
    a_addr_stable: assert property (p_addr_stable)
        else $error("port a address changed while waiting for resp");

endmodule : fetch_unit

// File: hdl/reg_file.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module reg_file
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  lc3b_reg  sr1,
    input  lc3b_reg  sr2,
    input  logic     we,
    input  logic     cc_we,
    input  lc3b_reg  wr_dest,
    input  lc3b_word wr_data,
    output lc3b_word sr1_data,
    output lc3b_word sr2_data,
    output lc3b_nzp  cc
);

    lc3b_word regs [`LC3B_NUM_REGS];
    lc3b_nzp  cc_q;
    lc3b_nzp  cc_next;

    assign cc_next = wr_data[15] ? 3'b100 : ((wr_data == 16'h0000) ? 3'b010 : 3'b001);

    always_ff @(posedge clk) begin
        if (we) regs[wr_dest] <= wr_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cc_q <= 3'b010; // z out of reset
        end else if (cc_we) begin
            cc_q <= cc_next;
        end
    end

    // write-through, decode sees the writeback of this cycle
    assign sr1_data = (we && (wr_dest == sr1)) ? wr_data : regs[sr1];
    assign sr2_data = (we && (wr_dest == sr2)) ? wr_data : regs[sr2];
    assign cc       = cc_q;

endmodule : reg_file

// File: hdl/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
    import lc3b_types::*;
(
    input  lc3b_control_word ctrl,
    input  lc3b_word         instruction,
    input  lc3b_word         pc,
    input  lc3b_word         src1_data,
    input  lc3b_word         src2_data,
    input  lc3b_nzp          cc,
    output lc3b_word         alu_out,
    output lc3b_word         adder_out,
    output logic             br_taken
);

    lc3b_word imm5;
    lc3b_word offset6_x2;
    lc3b_word offset9_x2;
    lc3b_word opb;

    // sign extension, offsets already scaled to bytes
    assign imm5       = {{11{instruction[4]}}, instruction[4:0]};
    assign offset6_x2 = {{9{instruction[5]}}, instruction[5:0], 1'b0};
    assign offset9_x2 = {{6{instruction[8]}}, instruction[8:0], 1'b0};

    assign opb = ctrl.opb_imm ? imm5 : src2_data;

    always_comb begin
        case (ctrl.alu_op)
            alu_add: alu_out = src1_data + opb;
            alu_and: alu_out = src1_data & opb;
            alu_not: alu_out = ~src1_data;
            default: alu_out = opb;
        endcase
    end

    // ldr/str use base+offset6, br/lea are relative to the next pc
    assign adder_out = ctrl.offset6_sel ? (src1_data + offset6_x2)
                                        : (pc + 16'd2 + offset9_x2);

    assign br_taken = ctrl.is_branch & (|(instruction[11:9] & cc));

endmodule : exec_unit

// File: hdl/mem_access.sv
`timescale 1ns/1ps

module mem_access
    import lc3b_types::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  lc3b_control_word ctrl,
    input  lc3b_word         address,
    input  lc3b_word         store_data,
    input  logic             resp_b,
    input  lc3b_word         rdata_b,
    output logic             read_b,
    output logic             write_b,
    output logic [1:0]       wmask_b,
    output lc3b_word         address_b,
    output lc3b_word         wdata_b,
    output lc3b_word         load_data,
    output logic             mem_busy
);

    typedef enum logic [1:0] {s_idle, s_wait, s_done} state_t;

    state_t   state;
    logic     req;
    lc3b_word data_q;

    // request goes out the cycle the op enters mem, none once done
    assign req       = (ctrl.mem_read | ctrl.mem_write) & (state != s_done);
    assign read_b    = req & ctrl.mem_read;
    assign write_b   = req & ctrl.mem_write;
    assign wmask_b   = {2{write_b}}; // word stores only
    assign address_b = address;
    assign wdata_b   = store_data;
    assign mem_busy  = req & ~resp_b;
    assign load_data = (state == s_done) ? data_q : rdata_b;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= s_idle;
        end else begin
            case (state)
                s_idle, s_wait: begin
                    if (req && resp_b) begin
                        state <= stall ? s_done : s_idle;
                    end else if (req) begin
                        state <= s_wait;
                    end
                end
                s_done:  if (!stall) state <= s_idle; // op leaves mem
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (read_b && resp_b) data_q <= rdata_b;
    end

    a_one_op: assert property (@(posedge clk) disable iff (!rst_n) !(read_b && write_b))
        else $error("port b read and write both high");

    // once waiting, the request and its address stay put until resp
    a_wait_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == s_wait) |-> (req && $stable(address_b)))
        else $error("port b request changed while waiting for resp");

endmodule : mem_access

// File: hdl/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
    import lc3b_types::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // port a, instruction fetch
    input  logic       resp_a,
    input  lc3b_word   rdata_a,
    output logic       read_a,
    output logic       write_a,
    output logic [1:0] wmask_a,
    output lc3b_word   address_a,
    output lc3b_word   wdata_a,

    // port b, loads and stores
    input  logic       resp_b,
    input  lc3b_word   rdata_b,
    output logic       read_b,
    output logic       write_b,
    output logic [1:0] wmask_b,
    output lc3b_word   address_b,
    output lc3b_word   wdata_b
);

    if_id_t           if_id_d, if_id_q;
    id_ex_t           id_ex_d, id_ex_q;
    ex_mem_t          ex_mem_d, ex_mem_q;
    mem_wb_t          mem_wb_d, mem_wb_q;
    lc3b_control_word id_ctrl;
    lc3b_reg          id_sr2;
    lc3b_word         fetch_pc, fetch_instr;
    lc3b_word         sr1_data, sr2_data;
    lc3b_word         alu_out, adder_out, load_data, wb_value;
    lc3b_nzp          cc;
    logic             stall, hold, flush, fetch_busy, mem_busy, br_taken;
    logic [1:0]       pc_sel;

    assign write_a = 1'b0; // fetch port is read only
    assign wmask_a = 2'b11;
    assign wdata_a = 16'h0000;

    fetch_unit fetch (
        .clk(clk), .rst_n(rst_n), .stall(stall), .hold(hold), .pc_sel(pc_sel),
        .br_target(adder_out), .resp_a(resp_a), .rdata_a(rdata_a), .read_a(read_a),
        .address_a(address_a), .pc(fetch_pc), .instruction(fetch_instr),
        .fetch_busy(fetch_busy)
    );

    assign if_id_d = '{pc: fetch_pc, instruction: fetch_instr};
    stage_buffer #(.payload_t(if_id_t)) if_id_buf (
        .clk(clk), .rst_n(rst_n), .load(~stall & ~hold), .flush(flush),
        .d(if_id_d), .q(if_id_q)
    );

    cpu_control control (
        .clk(clk), .rst_n(rst_n), .instruction(if_id_q.instruction),
        .id_ex_dest(id_ex_q.dest), .ex_mem_dest(ex_mem_q.dest), .mem_wb_dest(mem_wb_q.dest),
        .id_ex_ctrl(id_ex_q.ctrl), .ex_mem_ctrl(ex_mem_q.ctrl), .mem_wb_ctrl(mem_wb_q.ctrl),
        .fetch_busy(fetch_busy), .mem_busy(mem_busy), .br_taken(br_taken),
        .ctrl(id_ctrl), .stall(stall), .hold(hold), .flush(flush), .pc_sel(pc_sel)
    );

    assign id_sr2 = id_ctrl.mem_write ? if_id_q.instruction[11:9] : if_id_q.instruction[2:0];
    reg_file regs (
        .clk(clk), .rst_n(rst_n), .sr1(if_id_q.instruction[8:6]), .sr2(id_sr2),
        .we(mem_wb_q.ctrl.reg_write), .cc_we(mem_wb_q.ctrl.cc_write),
        .wr_dest(mem_wb_q.dest), .wr_data(mem_wb_q.value),
        .sr1_data(sr1_data), .sr2_data(sr2_data), .cc(cc)
    );

    assign id_ex_d = '{pc: if_id_q.pc, instruction: if_id_q.instruction, ctrl: id_ctrl,
                       dest: if_id_q.instruction[11:9], src1_data: sr1_data,
                       src2_data: sr2_data};
    stage_buffer #(.payload_t(id_ex_t)) id_ex_buf (
        .clk(clk), .rst_n(rst_n), .load(~stall), .flush(flush | (hold & ~stall)),
        .d(id_ex_d), .q(id_ex_q)
    );

    exec_unit exec (
        .ctrl(id_ex_q.ctrl), .instruction(id_ex_q.instruction), .pc(id_ex_q.pc),
        .src1_data(id_ex_q.src1_data), .src2_data(id_ex_q.src2_data), .cc(cc),
        .alu_out(alu_out), .adder_out(adder_out), .br_taken(br_taken)
    );

    assign ex_mem_d = '{ctrl: id_ex_q.ctrl, dest: id_ex_q.dest, alu: alu_out,
                        adder: adder_out, store_data: id_ex_q.src2_data};
    stage_buffer #(.payload_t(ex_mem_t)) ex_mem_buf (
        .clk(clk), .rst_n(rst_n), .load(~stall), .flush(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    mem_access mem (
        .clk(clk), .rst_n(rst_n), .stall(stall), .ctrl(ex_mem_q.ctrl),
        .address(ex_mem_q.adder), .store_data(ex_mem_q.store_data),
        .resp_b(resp_b), .rdata_b(rdata_b), .read_b(read_b), .write_b(write_b),
        .wmask_b(wmask_b), .address_b(address_b), .wdata_b(wdata_b),
        .load_data(load_data), .mem_busy(mem_busy)
    );

    // writeback value picked by the control word entering mem_wb
    always_comb begin
        case (ex_mem_q.ctrl.wb_sel)
            wb_mem:   wb_value = load_data;
            wb_adder: wb_value = ex_mem_q.adder;
            default:  wb_value = ex_mem_q.alu;
        endcase
    end

    assign mem_wb_d = '{ctrl: ex_mem_q.ctrl, dest: ex_mem_q.dest, value: wb_value};
    stage_buffer #(.payload_t(mem_wb_t)) mem_wb_buf (
        .clk(clk), .rst_n(rst_n), .load(~stall), .flush(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

endmodule : cpu_datapath

// File: verif/lc3b_mem_model.sv
`timescale 1ns/1ps

module lc3b_mem_model
    import lc3b_types::*;
#(
    parameter int words = 256
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       read_a,
    input  lc3b_word   address_a,
    output logic       resp_a,
    output lc3b_word   rdata_a,
    input  logic       read_b,
    input  logic       write_b,
    input  logic [1:0] wmask_b,
    input  lc3b_word   address_b,
    input  lc3b_word   wdata_b,
    output logic       resp_b,
    output lc3b_word   rdata_b,
    output logic       store_seen,
    output lc3b_word   store_addr,
    output lc3b_word   store_data
);

    localparam int aw = $clog2(words);

    lc3b_word mem [words];
    integer   seed;
    int       cnt_a;
    int       cnt_b;
    logic     pend_a;
    logic     pend_b;

    function automatic int pick_latency();
        return 1 + ($unsigned($random(seed)) % 4);
    endfunction

    initial begin
        seed       = 24;
        resp_a     = 1'b0;
        resp_b     = 1'b0;
        rdata_a    = '0;
        rdata_b    = '0;
        store_seen = 1'b0;
        store_addr = '0;
        store_data = '0;
        pend_a     = 1'b0;
        pend_b     = 1'b0;
        for (int i = 0; i < words; i++) begin
            mem[i] = lc3b_word'(i) * 16'h9e37; // odd multiplier, unique per word
        end
    end

    // byte addressed ports, word array
    always @(posedge clk) begin
        store_seen <= 1'b0;
        if (!rst_n) begin
            resp_a <= #1 1'b0;
            resp_b <= #1 1'b0;
            pend_a <= 1'b0;
            pend_b <= 1'b0;
        end else begin
            if (resp_a) begin
                resp_a <= #1 1'b0;  // one cycle pulse
            end else if (pend_a && cnt_a > 1) begin
                cnt_a <= cnt_a - 1;
            end else if (pend_a) begin
                pend_a  <= 1'b0;
                resp_a  <= #1 1'b1;
                rdata_a <= #1 mem[address_a[aw:1]];
            end else if (read_a) begin
                pend_a <= 1'b1;
                cnt_a  <= pick_latency();
            end

            if (resp_b) begin
                resp_b <= #1 1'b0;
            end else if (pend_b && cnt_b > 1) begin
                cnt_b <= cnt_b - 1;
            end else if (pend_b) begin
                pend_b <= 1'b0;
                resp_b <= #1 1'b1;
                if (write_b) begin
                    if (wmask_b[0]) mem[address_b[aw:1]][7:0] <= wdata_b[7:0];
                    if (wmask_b[1]) mem[address_b[aw:1]][15:8] <= wdata_b[15:8];
                    store_seen <= 1'b1;  // reported to the testbench
                    store_addr <= address_b;
                    store_data <= wdata_b;
                end else begin
                    rdata_b <= #1 mem[address_b[aw:1]];
                end
            end else if (read_b || write_b) begin
                pend_b <= 1'b1;
                cnt_b  <= pick_latency();
            end
        end
    end

endmodule : lc3b_mem_model

// File: verif/cpu_datapath_tb.sv
`timescale 1ns/1ps
`include "lc3b_cfg.svh"

module cpu_datapath_tb
    import lc3b_types::*;
();

    localparam int pat_words   = 128;
    localparam int image_words = 64;
    localparam int exp_base    = 64;  // store count, then address/data pairs

    logic       clk = 1'b0;
    logic       rst_n;
    logic       read_a;
    logic       write_a;
    logic       resp_a;
    logic [1:0] wmask_a;
    lc3b_word   address_a;
    lc3b_word   wdata_a;
    lc3b_word   rdata_a;
    logic       read_b;
    logic       write_b;
    logic       resp_b;
    logic [1:0] wmask_b;
    lc3b_word   address_b;
    lc3b_word   wdata_b;
    lc3b_word   rdata_b;
    logic       store_seen;
    lc3b_word   store_addr;
    lc3b_word   store_data;

    lc3b_word   pat [pat_words];
    int         n_expected;
    int         n_seen;
    int         n_checks;
    int         n_errors;
    logic       first_fetch_seen;
    logic       a_waiting;
    logic       b_waiting;
    logic       b_was_write;
    lc3b_word   a_addr_q;
    lc3b_word   b_addr_q;
    lc3b_word   b_data_q;

    cpu_datapath uut (
        .clk(clk), .rst_n(rst_n),
        .resp_a(resp_a), .rdata_a(rdata_a), .read_a(read_a), .write_a(write_a),
        .wmask_a(wmask_a), .address_a(address_a), .wdata_a(wdata_a),
        .resp_b(resp_b), .rdata_b(rdata_b), .read_b(read_b), .write_b(write_b),
        .wmask_b(wmask_b), .address_b(address_b), .wdata_b(wdata_b)
    );

    lc3b_mem_model mem_model (
        .clk(clk), .rst_n(rst_n),
        .read_a(read_a), .address_a(address_a), .resp_a(resp_a), .rdata_a(rdata_a),
        .read_b(read_b), .write_b(write_b), .wmask_b(wmask_b), .address_b(address_b),
        .wdata_b(wdata_b), .resp_b(resp_b), .rdata_b(rdata_b),
        .store_seen(store_seen), .store_addr(store_addr), .store_data(store_data)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    task automatic check(input string what, input lc3b_word got, input lc3b_word expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("[ERROR] %0t: %s, got %h, expected %h", $time, what, got, expected);
        end
    endtask

    // outputs sampled mid-cycle, all of them settled by then
    always @(negedge clk) begin
        if (!rst_n) begin
            check("read_a during reset", read_a, 16'h0000);
            check("read_b during reset", read_b, 16'h0000);
            check("write_b during reset", write_b, 16'h0000);
        end else begin
            check("write_a on fetch port", write_a, 16'h0000);
            check("wmask_a on fetch port", wmask_a, 16'h0003);
            check("wdata_a on fetch port", wdata_a, 16'h0000);
            if (write_b) check("wmask_b on word store", wmask_b, 16'h0003);
            if (read_a && !first_fetch_seen) begin
                check("first fetch address", address_a, `LC3B_RESET_PC);
                first_fetch_seen = 1'b1;
            end
            if (a_waiting) begin
                check("read_a held until resp", read_a, 16'h0001);
                check("address_a held until resp", address_a, a_addr_q);
            end
            if (b_waiting) begin
                check("write_b held until resp", write_b, b_was_write);
                check("read_b held until resp", read_b, !b_was_write);
                check("address_b held until resp", address_b, b_addr_q);
                if (b_was_write) check("wdata_b held until resp", wdata_b, b_data_q);
            end
            a_waiting   = read_a && !resp_a;
            a_addr_q    = address_a;
            b_waiting   = (read_b || write_b) && !resp_b;
            b_was_write = write_b;
            b_addr_q    = address_b;
            b_data_q    = wdata_b;

            if (store_seen) begin
                if (n_seen < n_expected) begin
                    check("store address", store_addr, pat[exp_base + 1 + 2 * n_seen]);
                    check("store data", store_data, pat[exp_base + 2 + 2 * n_seen]);
                end else begin
                    n_errors++;
                    $display("unexpected extra store of %h to address %h at %0t",
                             store_data, store_addr, $time);
                end
                n_seen++;
            end
        end
    end

    initial begin
        rst_n            = 1'b0;
        n_seen           = 0;
        n_checks         = 0;
        n_errors         = 0;
        first_fetch_seen = 1'b0;
        a_waiting        = 1'b0;
        b_waiting        = 1'b0;
        b_was_write      = 1'b0;
        a_addr_q         = '0;
        b_addr_q         = '0;
        b_data_q         = '0;
        $readmemh("verif/cpu_patterns.txt", pat);
        n_expected = $isunknown(pat[exp_base]) ? 0 : int'(pat[exp_base]);

        @(posedge clk);
        for (int i = 0; i < image_words; i++) begin
            if (!$isunknown(pat[i])) mem_model.mem[i] = pat[i];
        end
        repeat (7) @(posedge clk);
        #1 rst_n = 1'b1;

        wait (n_seen >= n_expected);
        repeat (50) @(posedge clk);  // room for a stray store to show up

        $display("checks %0d, stores %0d of %0d, errors %0d",
                 n_checks, n_seen, n_expected, n_errors);
        if (n_errors == 0 && n_expected > 0 && n_seen == n_expected && first_fetch_seen) begin
            $display("Test completed successfully");
        end else begin
            if (n_expected == 0) $display("pattern file gave no expected stores");
            $display("Test failed");
        end
        $finish;
    end

    // budget of 200 cycles per expected store
    initial begin
        #1;
        repeat (8 + n_expected * 200) @(posedge clk);
        $display("watchdog expired, the core hung with %0d of %0d stores seen",
                 n_seen, n_expected);
        $display("Test failed");
        $finish;
    end

endmodule : cpu_datapath_tb

// File: verif/cpu_patterns.txt
// words 0x00..0x3f program image, word per instruction at byte address 2*index
// word 0x40 store count, then one store per line as address and data
@000
5020 EC7E 1225 143D 1642 5866 5A81 9E7F  // r0=0 r6=lea 0100 r1=5 r2=-3 r3=2 r4=4 r5=5 r7=fffa
7D80 7781 7982 7B83 7F84                 // str r6 r3 r4 r5 r7 to slots 0..4
6384 1443 7585                           // ldr r1 slot 4, add r2=r1+r3, str slot 5
0801 7B9F 0401 7786                      // cc n: brn skips bad str, brz falls into slot 6
5FE0 0201 7987 0401 7B9F                 // cc z: brp falls into slot 7, brz skips bad str
1FE9 0801 7F88 0201 7B9F                 // cc p: brn falls into slot 8, brp skips bad str
5260 1263 1FC7 127F 03FD 7F89 0FFF       // loop 3 times doubling r7, slot 9, spin
@040
000A
0100 0100
0102 0002
0104 0004
0106 0005
0108 FFFA
010A FFFC
010C 0002
010E 0004
0110 0009
0112 0048

// File: cpu_datapath.f
+incdir+common
common/lc3b_types.sv
hdl/stage_buffer.sv
hdl/cpu_control.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/mem_access.sv
hdl/cpu_datapath.sv
verif/lc3b_mem_model.sv
verif/cpu_datapath_tb.sv

// File: Bender.yml
package:
  name: lc3b_pipeline

sources:
  - include_dirs:
      - common
    files:
      - common/lc3b_types.sv
      - hdl/stage_buffer.sv
      - hdl/cpu_control.sv
      - hdl/fetch_unit.sv
      - hdl/reg_file.sv
      - hdl/exec_unit.sv
      - hdl/mem_access.sv
      - hdl/cpu_datapath.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/lc3b_mem_model.sv
      - verif/cpu_datapath_tb.sv
